//--- flist.f
rtl/axiApbPkg.sv
rtl/writeEngine.sv
rtl/readEngine.sv
rtl/wordPortArbiter.sv
rtl/axiApbSlaveIf.sv
tb/axiApbSlaveIf_checker.sv
tb/tbAxiApbSlaveIf.sv

//--- tb/tbAxiApbSlaveIf.sv
// testbench for the bridge top level: random AXI bursts against a word-target and reference model
`timescale 1ns/1ps

module tbAxiApbSlaveIf;
  localparam int DW = 64;
  localparam int WaitLimit = 2000;  // cycles per wait

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
  } wordRec;

  logic ACLK, ARESETn;
  logic [7:0] AWID, ARID, BID, RID;
  logic [31:0] AWADDR, ARADDR, ADDR, DATAW;
  axiApbPkg::axiLen AWLEN, ARLEN;
  axiApbPkg::axiSize AWSIZE, ARSIZE;
  logic [1:0] AWBURST, ARBURST, BRESP, RRESP;
  logic AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
  logic ARVALID, ARREADY, RLAST, RVALID, RREADY, REQ, WR;
  logic [DW-1:0] WDATA, RDATA;
  logic [DW/8-1:0] WSTRB;
  logic [3:0] BE;
  logic ACK = 1'b0;
  logic [31:0] DATAR = '0;

  logic [15:0] stimLfsr = 16'd9;
  logic [15:0] ackLfsr = 16'd9;
  logic [31:0] targetMem [logic [31:0]];
  logic [31:0] refMem [logic [31:0]];
  wordRec logQ[$];  // every word transfer seen on the port
  wordRec expQ[$];  // predicted word writes
  int errCount = 0;

  axiApbSlaveIf #(.DataWidth(DW), .AddrWidth(32), .IdWidth(8)) axiApbSlaveIf_i (.*);

  initial begin
    ACLK = 1'b0;
    forever #5 ACLK = ~ACLK;
  end

  // ------------------------------
  // helpers and reference rules
  // ------------------------------
  function automatic logic [31:0] takeBits(inout logic [15:0] st, input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = st[15] ^ st[13] ^ st[12] ^ st[10];  // x^16+x^14+x^13+x^11
      st = {st[14:0], fb};
      r  = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] fillOf(input logic [31:0] a);
    return (a * 32'h9E37_79B1) ^ 32'h0F0F_1234;
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] nw,
                                             input logic [3:0] be);
    for (int b = 0; b < 4; b++) if (be[b]) old[8*b +: 8] = nw[8*b +: 8];
    return old;
  endfunction

  function automatic logic [7:0] byteMask(input logic [31:0] a, input axiApbPkg::axiSize sz);
    logic [15:0] ones;
    ones = (16'd1 << (1 << sz)) - 16'd1;
    return 8'(ones << a[2:0]);
  endfunction

  function automatic logic [31:0] stepAddr(input logic [31:0] a, input axiApbPkg::axiSize sz,
                                           input logic [1:0] burst);
    if (burst != axiApbPkg::burstIncr) return a;
    if ((1 << sz) < DW / 8) return a + (32'd1 << sz);
    return {a[31:3], 3'b000} + 32'd8;
  endfunction

  task automatic abortRun(input string msg);
    $display("ERROR: %s", msg);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic checkWord(input wordRec got, input wordRec exp);
    if (got.addr !== exp.addr) begin
      errCount++;
      $display("[FAIL] ADDR got 0x%h expected 0x%h", got.addr, exp.addr);
    end
    if (got.data !== exp.data) begin
      errCount++;
      $display("[FAIL] DATAW got 0x%h expected 0x%h", got.data, exp.data);
    end
    if (got.be !== exp.be) begin
      errCount++;
      $display("[FAIL] BE got 0x%h expected 0x%h", got.be, exp.be);
    end
  endtask

  task automatic checkBeat(input logic [DW-1:0] expData, input logic expLast,
                           input logic [7:0] expId, input axiApbPkg::respCode expResp);
    if (RDATA !== expData) begin
      errCount++;
      $display("[FAIL] RDATA got 0x%h expected 0x%h", RDATA, expData);
    end
    if (RLAST !== expLast) begin
      errCount++;
      $display("[FAIL] RLAST got 0x%h expected 0x%h", RLAST, expLast);
    end
    if (RID !== expId) begin
      errCount++;
      $display("[FAIL] RID got 0x%h expected 0x%h", RID, expId);
    end
    if (RRESP !== expResp) begin
      errCount++;
      $display("[FAIL] RRESP got 0x%h expected 0x%h", RRESP, expResp);
    end
  endtask

  task automatic checkResp(input logic [7:0] expId, input axiApbPkg::respCode expResp);
    if (BID !== expId) begin
      errCount++;
      $display("[FAIL] BID got 0x%h expected 0x%h", BID, expId);
    end
    if (BRESP !== expResp) begin
      errCount++;
      $display("[FAIL] BRESP got 0x%h expected 0x%h", BRESP, expResp);
    end
  endtask

  // observed writes against the prediction, no read word while writes are still pending
  task automatic checkLog;
    wordRec r;
    while (logQ.size() > 0) begin
      r = logQ.pop_front();
      if (!r.wr) begin
        if (expQ.size() != 0) begin
          errCount++;
          $display("ERROR: read word at 0x%h came before %0d pending word writes",
                   r.addr, expQ.size());
        end
      end else if (expQ.size() == 0) begin
        errCount++;
        $display("ERROR: unexpected word write at 0x%h", r.addr);
      end else begin
        checkWord(r, expQ.pop_front());
      end
    end
    if (expQ.size() != 0) begin
      errCount++;
      $display("ERROR: %0d predicted word writes never appeared", expQ.size());
    end
    expQ.delete();
  endtask

  // ------------------------------
  // word target: random ACK delay
  // ------------------------------
  always @(posedge ACLK) begin : wordTarget
    logic [31:0] cur;
    int ackWait;
    #1;
    if (!ARESETn) begin
      ACK = 1'b0;
      ackWait = takeBits(ackLfsr, 2);
    end else if (!ACK && REQ) begin
      if (ackWait != 0) begin
        ackWait--;
      end else begin
        cur = targetMem.exists(ADDR) ? targetMem[ADDR] : fillOf(ADDR);
        DATAR = cur;
        if (WR) targetMem[ADDR] = mergeBytes(cur, DATAW, BE);
        logQ.push_back('{WR, ADDR, DATAW, BE});
        ACK = 1'b1;
      end
    end else if (ACK && !REQ) begin
      ACK = 1'b0;
      ackWait = takeBits(ackLfsr, 2);
    end
  end

  // ------------------------------
  // AXI bursts
  // ------------------------------
  task automatic writeBurst(input logic [7:0] id, input logic [31:0] addr,
                            input axiApbPkg::axiSize sz, input logic [1:0] burst,
                            input axiApbPkg::axiLen len, input bit dropLast, input int stallBits);
    logic [DW-1:0] dataQ[$];
    logic [DW/8-1:0] strbQ[$];
    logic [DW-1:0] d;
    logic [7:0] s;
    logic [31:0] a, wa;
    int tries;
    a = addr;
    for (int b = 0; b <= len; b++) begin  // predict first
      d = {takeBits(stimLfsr, 32), takeBits(stimLfsr, 32)};
      s = 8'(takeBits(stimLfsr, 8)) & byteMask(a, sz);
      for (int l = a[2]; l < 2; l++) begin
        if (s[4*l +: 4] != 0) begin
          wa = {a[31:3], 3'b000} | (l << 2);
          expQ.push_back('{1'b1, wa, d[32*l +: 32], s[4*l +: 4]});
          refMem[wa] = mergeBytes(refMem.exists(wa) ? refMem[wa] : fillOf(wa),
                                  d[32*l +: 32], s[4*l +: 4]);
        end
      end
      dataQ.push_back(d);
      strbQ.push_back(s);
      a = stepAddr(a, sz, burst);
    end
    @(posedge ACLK);
    #1;
    {AWID, AWADDR, AWSIZE, AWBURST, AWLEN, AWVALID} = {id, addr, sz, burst, len, 1'b1};
    tries = 0;
    do begin
      @(negedge ACLK);
      tries++;
    end while (!AWREADY && tries < WaitLimit);
    if (!AWREADY) abortRun("AWREADY never rose");
    @(posedge ACLK);
    #1 AWVALID = 1'b0;
    for (int b = 0; b <= len; b++) begin
      {WDATA, WSTRB, WVALID} = {dataQ[b], strbQ[b], 1'b1};
      WLAST = (b == len) && !dropLast;
      tries = 0;
      do begin
        @(negedge ACLK);
        tries++;
      end while (!WREADY && tries < WaitLimit);
      if (!WREADY) abortRun("WREADY never rose");
      @(posedge ACLK);
      #1 WVALID = 1'b0;
    end
    tries = 0;
    do begin
      @(negedge ACLK);
      tries++;
    end while (!BVALID && tries < WaitLimit);
    if (!BVALID) abortRun("no B response");
    repeat (takeBits(stimLfsr, stallBits)) @(negedge ACLK);  // back-pressure
    @(posedge ACLK);
    #1 BREADY = 1'b1;
    @(negedge ACLK);
    checkResp(id, (dropLast || burst == axiApbPkg::burstWrap) ?
              axiApbPkg::respSlvErr : axiApbPkg::respOkay);
    @(posedge ACLK);
    #1 BREADY = 1'b0;
    checkLog();
  endtask

  task automatic readBurst(input logic [7:0] id, input logic [31:0] addr,
                           input axiApbPkg::axiSize sz, input logic [1:0] burst,
                           input axiApbPkg::axiLen len, input int stallBits);
    logic [DW-1:0] expData;
    logic [7:0] m;
    logic [31:0] a, wa;
    int tries;
    @(posedge ACLK);
    #1;
    {ARID, ARADDR, ARSIZE, ARBURST, ARLEN, ARVALID} = {id, addr, sz, burst, len, 1'b1};
    tries = 0;
    do begin
      @(negedge ACLK);
      tries++;
    end while (!ARREADY && tries < WaitLimit);
    if (!ARREADY) abortRun("ARREADY never rose");
    @(posedge ACLK);
    #1 ARVALID = 1'b0;
    a = addr;
    for (int b = 0; b <= len; b++) begin
      tries = 0;
      do begin
        @(negedge ACLK);
        tries++;
      end while (!RVALID && tries < WaitLimit);
      if (!RVALID) abortRun("R beat never arrived");
      expData = '0;
      m = byteMask(a, sz);
      for (int l = a[2]; l < 2; l++) begin
        wa = {a[31:3], 3'b000} | (l << 2);
        if (m[4*l +: 4] != 0) expData[32*l +: 32] = refMem.exists(wa) ? refMem[wa] : fillOf(wa);
      end
      repeat (takeBits(stimLfsr, stallBits)) @(negedge ACLK);
      @(posedge ACLK);
      #1 RREADY = 1'b1;
      @(negedge ACLK);
      checkBeat(expData, b == len, id, (burst == axiApbPkg::burstWrap) ?
                axiApbPkg::respSlvErr : axiApbPkg::respOkay);
      @(posedge ACLK);
      #1 RREADY = 1'b0;
      a = stepAddr(a, sz, burst);
    end
    checkLog();
  endtask

  function automatic logic [31:0] pickAddr(input axiApbPkg::axiSize sz);
    return 32'h0000_1000 | (takeBits(stimLfsr, 7) & ~((32'd1 << sz) - 32'd1));
  endfunction

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : mainSeq
    axiApbPkg::axiSize sz;
    logic [31:0] a;
    logic [7:0] id;
    {AWID, AWADDR, AWLEN, AWSIZE, AWBURST, AWVALID} = '0;
    {WDATA, WSTRB, WLAST, WVALID, BREADY} = '0;
    {ARID, ARADDR, ARLEN, ARSIZE, ARBURST, ARVALID, RREADY} = '0;
    ARESETn = 1'b0;
    repeat (8) @(posedge ACLK);
    #1 ARESETn = 1'b1;

    for (int i = 0; i < 6; i++) begin  // single beats, write then read back
      sz = 3'(2 + takeBits(stimLfsr, 1));
      a  = pickAddr(sz);
      id = 8'(takeBits(stimLfsr, 8));
      writeBurst(id, a, sz, axiApbPkg::burstIncr, 8'd0, 1'b0, 1);
      readBurst(id + 8'd1, a, sz, axiApbPkg::burstIncr, 8'd0, 1);
    end
    for (int i = 0; i < 5; i++) begin  // INCR write bursts
      sz = 3'(takeBits(stimLfsr, 2));
      writeBurst(8'(takeBits(stimLfsr, 8)), pickAddr(sz), sz, axiApbPkg::burstIncr,
                 8'(takeBits(stimLfsr, 3)), 1'b0, 1);
    end
    for (int i = 0; i < 6; i++) begin  // narrow INCR and FIXED reads
      sz = 3'(takeBits(stimLfsr, 2) % 3);
      readBurst(8'(takeBits(stimLfsr, 8)), pickAddr(sz), sz,
                (i % 2) ? axiApbPkg::burstFixed : axiApbPkg::burstIncr,
                8'(takeBits(stimLfsr, 3)), 1);
    end
    // error responses
    writeBurst(8'h3C, pickAddr(3'd3), 3'd3, axiApbPkg::burstIncr, 8'd2, 1'b1, 1);
    writeBurst(8'h5A, pickAddr(3'd2), 3'd2, axiApbPkg::burstWrap, 8'd3, 1'b0, 1);
    readBurst(8'h6B, pickAddr(3'd2), 3'd2, axiApbPkg::burstWrap, 8'd3, 1);
    // AW and AR in the same cycle
    fork
      writeBurst(8'h11, 32'h0000_1040, 3'd3, axiApbPkg::burstIncr, 8'd3, 1'b0, 1);
      readBurst(8'h22, 32'h0000_1040, 3'd3, axiApbPkg::burstIncr, 8'd3, 1);
    join
    for (int i = 0; i < 4; i++) begin  // long BREADY / RREADY stalls
      sz = 3'(takeBits(stimLfsr, 2));
      a  = pickAddr(sz);
      writeBurst(8'(i), a, sz, axiApbPkg::burstIncr, 8'(takeBits(stimLfsr, 2)), 1'b0, 4);
      readBurst(8'(i + 8), a, sz, axiApbPkg::burstIncr, 8'(takeBits(stimLfsr, 2)), 4);
    end

    repeat (5) @(posedge ACLK);
    $display("errors %0d, assertion failures %0d", errCount, axiApbSlaveIf_i.checker_i.failCount);
    if (errCount == 0 && axiApbSlaveIf_i.checker_i.failCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tb/axiApbSlaveIf_checker.sv
// protocol assertions for the bridge top level, attached by the bind at the end of this file
`timescale 1ns/1ps

module axiApbSlaveIf_checker #(
  parameter int DataWidth = 64,
  parameter int AddrWidth = 32
) (
  input logic                                 ACLK,
  input logic                                 ARESETn,
  input logic                                 REQ,
  input logic [AddrWidth-1:0]                 ADDR,
  input logic                                 WR,
  input logic [axiApbPkg::wordWidth-1:0]      DATAW,
  input logic [axiApbPkg::wordBytes-1:0]      BE,
  input logic                                 AWREADY,
  input logic                                 BVALID,
  input logic                                 BREADY,
  input logic                                 RVALID,
  input logic                                 RREADY,
  input logic                                 RLAST,
  input logic [DataWidth-1:0]                 RDATA
);
  int failCount = 0;  // failed assertions so far

  // word request fields frozen while REQ stays high
  reqStable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (REQ && $past(REQ)) |-> $stable({ADDR, WR, DATAW, BE}))
    else begin
      failCount++;
      $error("word request changed while REQ was high");
    end

  bHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (BVALID && !BREADY) |=> BVALID)
    else begin
      failCount++;
      $error("BVALID dropped before BREADY");
    end

  rHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (RVALID && !RREADY) |=> (RVALID && $stable(RDATA) && $stable(RLAST)))
    else begin
      failCount++;
      $error("R beat changed before RREADY");
    end

  awPulse: assert property (@(posedge ACLK) disable iff (!ARESETn)
    AWREADY |=> !AWREADY)
    else begin
      failCount++;
      $error("AWREADY longer than one cycle");
    end

endmodule

bind axiApbSlaveIf axiApbSlaveIf_checker #(.DataWidth(DataWidth), .AddrWidth(AddrWidth))
  checker_i (.*);

//--- rtl/axiApbSlaveIf.sv
// top level of the AXI slave side of the AXI-to-APB bridge, connects both engines to the word port
`timescale 1ns/1ps

module axiApbSlaveIf #(
  parameter int DataWidth = 64,  // 32, 64 or 128
  parameter int AddrWidth = 32,
  parameter int IdWidth   = 8
) (
  input  logic                             ACLK,
  input  logic                             ARESETn,
  // write address, data and response
  input  logic [IdWidth-1:0]               AWID,
  input  logic [AddrWidth-1:0]             AWADDR,
  input  axiApbPkg::axiLen                 AWLEN,
  input  axiApbPkg::axiSize                AWSIZE,
  input  logic [1:0]                       AWBURST,
  input  logic                             AWVALID,
  output logic                             AWREADY,
  input  logic [DataWidth-1:0]             WDATA,
  input  logic [DataWidth/8-1:0]           WSTRB,
  input  logic                             WLAST,
  input  logic                             WVALID,
  output logic                             WREADY,
  output logic [IdWidth-1:0]               BID,
  output logic [1:0]                       BRESP,
  output logic                             BVALID,
  input  logic                             BREADY,
  // read address and data
  input  logic [IdWidth-1:0]               ARID,
  input  logic [AddrWidth-1:0]             ARADDR,
  input  axiApbPkg::axiLen                 ARLEN,
  input  axiApbPkg::axiSize                ARSIZE,
  input  logic [1:0]                       ARBURST,
  input  logic                             ARVALID,
  output logic                             ARREADY,
  output logic [IdWidth-1:0]               RID,
  output logic [DataWidth-1:0]             RDATA,
  output logic [1:0]                       RRESP,
  output logic                             RLAST,
  output logic                             RVALID,
  input  logic                             RREADY,
  // word port toward the APB master
  output logic                             REQ,
  input  logic                             ACK,
  output logic [AddrWidth-1:0]             ADDR,
  output logic                             WR,
  output logic [axiApbPkg::wordWidth-1:0]  DATAW,
  input  logic [axiApbPkg::wordWidth-1:0]  DATAR,
  output logic [axiApbPkg::wordBytes-1:0]  BE
);
  logic                            writeWant;
  logic                            writeGrant;
  logic                            writeReq;
  logic [AddrWidth-1:0]            writeAddr;
  logic [axiApbPkg::wordWidth-1:0] writeData;
  logic [axiApbPkg::wordBytes-1:0] writeBe;
  logic                            readWant;
  logic                            readGrant;
  logic                            readReq;
  logic [AddrWidth-1:0]            readAddr;
  logic [axiApbPkg::wordBytes-1:0] readBe;
  logic                            ackSync;  // ACK two ACLK later

  writeEngine #(.DataWidth(DataWidth), .AddrWidth(AddrWidth), .IdWidth(IdWidth)) writeEngine_i (
    .*,
    .portWant(writeWant),
    .wordReq (writeReq),
    .wordAddr(writeAddr),
    .wordData(writeData),
    .wordBe  (writeBe)
  );

  readEngine #(.DataWidth(DataWidth), .AddrWidth(AddrWidth), .IdWidth(IdWidth)) readEngine_i (
    .*,
    .portWant(readWant),
    .wordReq (readReq),
    .wordAddr(readAddr),
    .wordBe  (readBe)
  );

  wordPortArbiter #(.AddrWidth(AddrWidth)) wordPortArbiter_i (.*);

endmodule

//--- rtl/wordPortArbiter.sv
// word-port side of the bridge: ACK synchronizer, write-first grant and request multiplexer
`timescale 1ns/1ps

module wordPortArbiter #(
  parameter int AddrWidth = 32
) (
  input  logic                             ACLK,
  input  logic                             ARESETn,
  input  logic                             ACK,
  input  logic                             writeWant,
  input  logic                             readWant,
  input  logic                             writeReq,
  input  logic [AddrWidth-1:0]             writeAddr,
  input  logic [axiApbPkg::wordWidth-1:0]  writeData,
  input  logic [axiApbPkg::wordBytes-1:0]  writeBe,
  input  logic                             readReq,
  input  logic [AddrWidth-1:0]             readAddr,
  input  logic [axiApbPkg::wordBytes-1:0]  readBe,
  output logic                             writeGrant,
  output logic                             readGrant,
  output logic                             ackSync,
  output logic                             REQ,
  output logic [AddrWidth-1:0]             ADDR,
  output logic                             WR,
  output logic [axiApbPkg::wordWidth-1:0]  DATAW,
  output logic [axiApbPkg::wordBytes-1:0]  BE
);
  logic ackMeta;  // first synchronizer stage

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      ackMeta <= 1'b0;
      ackSync <= 1'b0;
    end else begin
      ackMeta <= ACK;
      ackSync <= ackMeta;
    end
  end

  // ------------------------------
  // grant, held until want drops
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      writeGrant <= 1'b0;
      readGrant  <= 1'b0;
    end else if (!writeGrant && !readGrant) begin
      writeGrant <= writeWant;              // write wins a tie
      readGrant  <= readWant && !writeWant;
    end else begin
      if (writeGrant && !writeWant) writeGrant <= 1'b0;
      if (readGrant && !readWant) readGrant <= 1'b0;
    end
  end

  always_comb begin
    REQ   = 1'b0;
    ADDR  = '0;
    WR    = 1'b0;
    DATAW = '0;
    BE    = '0;
    if (writeGrant) begin
      REQ   = writeReq;
      ADDR  = writeAddr;
      WR    = 1'b1;
      DATAW = writeData;
      BE    = writeBe;
    end else if (readGrant) begin
      REQ  = readReq;
      ADDR = readAddr;
      BE   = readBe;
    end
  end

endmodule

//--- rtl/readEngine.sv
// AXI read side of the bridge: takes AR, reads the covered word lanes, presents each R beat
`timescale 1ns/1ps

module readEngine #(
  parameter int DataWidth = 64,
  parameter int AddrWidth = 32,
  parameter int IdWidth   = 8
) (
  input  logic                             ACLK,
  input  logic                             ARESETn,
  input  logic [IdWidth-1:0]               ARID,
  input  logic [AddrWidth-1:0]             ARADDR,
  input  axiApbPkg::axiLen                 ARLEN,
  input  axiApbPkg::axiSize                ARSIZE,
  input  logic [1:0]                       ARBURST,
  input  logic                             ARVALID,
  output logic                             ARREADY,
  output logic [IdWidth-1:0]               RID,
  output logic [DataWidth-1:0]             RDATA,
  output logic [1:0]                       RRESP,
  output logic                             RLAST,
  output logic                             RVALID,
  input  logic                             RREADY,
  input  logic                             readGrant,
  input  logic                             ackSync,
  input  logic [axiApbPkg::wordWidth-1:0]  DATAR,
  output logic                             portWant,
  output logic                             wordReq,
  output logic [AddrWidth-1:0]             wordAddr,
  output logic [axiApbPkg::wordBytes-1:0]  wordBe
);
  localparam int BusBytes = DataWidth / 8;
  localparam int Lanes    = DataWidth / axiApbPkg::wordWidth;
  localparam int LaneBits = (Lanes > 1) ? $clog2(Lanes) : 1;

  typedef enum logic [2:0] {
    rIdle, rGrant, rAddr, rLane, rAck, rDrop, rNext, rBeat
  } rState;

  rState                           state;
  logic [AddrWidth-1:0]            beatAddr;
  logic [AddrWidth-1:0]            nextAddr;
  axiApbPkg::axiLen                burstLen;
  axiApbPkg::axiLen                beatCnt;
  axiApbPkg::axiSize               beatSize;
  axiApbPkg::burstKind             burstType;
  logic [15:0]                     beatMask;  // bytes this beat covers
  logic [LaneBits-1:0]             lane;
  logic [axiApbPkg::wordBytes-1:0] laneBe;
  logic                            lastLane;
  logic                            lastBeat;

  assign nextAddr = AddrWidth'(axiApbPkg::nextBeatAddr(axiApbPkg::addrWord'(beatAddr),
                                                       beatSize, burstType, BusBytes));
  assign beatMask = axiApbPkg::sizeMask(axiApbPkg::addrWord'(beatAddr), beatSize, BusBytes);
  assign laneBe   = beatMask[lane*axiApbPkg::wordBytes +: axiApbPkg::wordBytes];
  assign lastLane = (lane == LaneBits'(Lanes - 1));
  assign lastBeat = (beatCnt == burstLen);

  // ------------------------------
  // burst FSM
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state    <= rIdle;
      portWant <= 1'b0;
      ARREADY  <= 1'b0;
      RVALID   <= 1'b0;
      RLAST    <= 1'b0;
      wordReq  <= 1'b0;
      lane     <= '0;
      beatCnt  <= '0;
    end else begin
      case (state)
        rIdle: if (ARVALID) begin
          portWant <= 1'b1;
          state    <= rGrant;
        end
        rGrant: if (readGrant) begin
          ARREADY <= 1'b1;
          state   <= rAddr;
        end
        rAddr: begin
          ARREADY <= 1'b0;
          beatCnt <= '0;
          lane    <= LaneBits'(axiApbPkg::laneOf(axiApbPkg::addrWord'(ARADDR), BusBytes));
          state   <= rLane;
        end
        rLane: begin
          if (laneBe != '0) begin
            wordReq <= 1'b1;
            state   <= rAck;
          end else begin
            state <= rNext;  // lane outside the transfer size
          end
        end
        rAck: if (ackSync) begin
          wordReq <= 1'b0;
          state   <= rDrop;
        end
        rDrop: if (!ackSync) state <= rNext;
        rNext: begin
          if (!lastLane) begin
            lane  <= lane + LaneBits'(1);
            state <= rLane;
          end else begin
            RVALID <= 1'b1;
            RLAST  <= lastBeat;
            state  <= rBeat;
          end
        end
        rBeat: if (RREADY) begin
          RVALID <= 1'b0;
          RLAST  <= 1'b0;
          if (lastBeat) begin
            portWant <= 1'b0;
            state    <= rIdle;
          end else begin
            beatCnt <= beatCnt + 1'b1;
            lane    <= LaneBits'(axiApbPkg::laneOf(axiApbPkg::addrWord'(nextAddr), BusBytes));
            state   <= rLane;
          end
        end
        default: state <= rIdle;
      endcase
    end
  end

  // captured fields, word request and beat assembly
  always_ff @(posedge ACLK) begin
    if (state == rAddr) begin
      RID       <= ARID;
      beatAddr  <= ARADDR;
      burstLen  <= ARLEN;
      beatSize  <= ARSIZE;
      burstType <= axiApbPkg::burstKind'(ARBURST);
      RDATA     <= '0;
    end
    if (state == rLane) begin
      wordAddr <= (beatAddr & ~AddrWidth'(BusBytes - 1)) | AddrWidth'({lane, 2'b00});
      wordBe   <= laneBe;
    end
    if (state == rAck && ackSync) begin
      RDATA[lane*axiApbPkg::wordWidth +: axiApbPkg::wordWidth] <= DATAR;  // ACK still high here
    end
    if (state == rNext && lastLane) begin
      RRESP <= (burstType == axiApbPkg::burstWrap) ? axiApbPkg::respSlvErr : axiApbPkg::respOkay;
    end
    if (state == rBeat && RREADY && !lastBeat) begin
      beatAddr <= nextAddr;
      RDATA    <= '0;  // unread lanes stay zero
    end
  end

endmodule

//--- rtl/writeEngine.sv
// AXI write side of the bridge: takes AW and W beats, issues one word write per non-empty lane
`timescale 1ns/1ps

module writeEngine #(
  parameter int DataWidth = 64,
  parameter int AddrWidth = 32,
  parameter int IdWidth   = 8
) (
  input  logic                             ACLK,
  input  logic                             ARESETn,
  input  logic [IdWidth-1:0]               AWID,
  input  logic [AddrWidth-1:0]             AWADDR,
  input  axiApbPkg::axiLen                 AWLEN,
  input  axiApbPkg::axiSize                AWSIZE,
  input  logic [1:0]                       AWBURST,
  input  logic                             AWVALID,
  output logic                             AWREADY,
  input  logic [DataWidth-1:0]             WDATA,
  input  logic [DataWidth/8-1:0]           WSTRB,
  input  logic                             WLAST,
  input  logic                             WVALID,
  output logic                             WREADY,
  output logic [IdWidth-1:0]               BID,
  output logic [1:0]                       BRESP,
  output logic                             BVALID,
  input  logic                             BREADY,
  input  logic                             writeGrant,
  input  logic                             ackSync,
  output logic                             portWant,
  output logic                             wordReq,
  output logic [AddrWidth-1:0]             wordAddr,
  output logic [axiApbPkg::wordWidth-1:0]  wordData,
  output logic [axiApbPkg::wordBytes-1:0]  wordBe
);
  localparam int BusBytes = DataWidth / 8;
  localparam int Lanes    = DataWidth / axiApbPkg::wordWidth;
  localparam int LaneBits = (Lanes > 1) ? $clog2(Lanes) : 1;

  typedef enum logic [3:0] {
    wIdle, wGrant, wAddr, wData, wLane, wAck, wDrop, wNext, wResp
  } wState;

  wState                           state;
  logic [IdWidth-1:0]              awId;
  logic [AddrWidth-1:0]            beatAddr;
  logic [AddrWidth-1:0]            nextAddr;
  logic [AddrWidth-1:0]            laneAddr;
  axiApbPkg::axiLen                burstLen;
  axiApbPkg::axiLen                beatCnt;
  axiApbPkg::axiSize               beatSize;
  axiApbPkg::burstKind             burstType;
  logic [DataWidth-1:0]            beatData;
  logic [BusBytes-1:0]             beatStrb;
  logic [LaneBits-1:0]             lane;
  logic [axiApbPkg::wordBytes-1:0] laneBe;
  logic                            lastLane;
  logic                            lastBeat;
  logic                            missingLast;  // final beat came without WLAST

  assign nextAddr = AddrWidth'(axiApbPkg::nextBeatAddr(axiApbPkg::addrWord'(beatAddr),
                                                       beatSize, burstType, BusBytes));
  assign laneAddr = (beatAddr & ~AddrWidth'(BusBytes - 1)) | AddrWidth'({lane, 2'b00});
  assign laneBe   = beatStrb[lane*axiApbPkg::wordBytes +: axiApbPkg::wordBytes];
  assign lastLane = (lane == LaneBits'(Lanes - 1));
  assign lastBeat = (beatCnt == burstLen);

  // ------------------------------
  // burst FSM
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state       <= wIdle;
      portWant    <= 1'b0;
      AWREADY     <= 1'b0;
      WREADY      <= 1'b0;
      BVALID      <= 1'b0;
      wordReq     <= 1'b0;
      lane        <= '0;
      beatCnt     <= '0;
      missingLast <= 1'b0;
    end else begin
      case (state)
        wIdle: if (AWVALID) begin
          portWant <= 1'b1;
          state    <= wGrant;
        end
        wGrant: if (writeGrant) begin
          AWREADY <= 1'b1;  // single-cycle pulse
          state   <= wAddr;
        end
        wAddr: begin
          AWREADY     <= 1'b0;
          WREADY      <= 1'b1;
          beatCnt     <= '0;
          missingLast <= 1'b0;
          lane        <= LaneBits'(axiApbPkg::laneOf(axiApbPkg::addrWord'(AWADDR), BusBytes));
          state       <= wData;
        end
        wData: if (WVALID) begin
          WREADY <= 1'b0;
          if (lastBeat && !WLAST) missingLast <= 1'b1;
          state  <= wLane;
        end
        wLane: begin
          if (laneBe != '0) begin
            wordReq <= 1'b1;
            state   <= wAck;
          end else begin
            state <= wNext;  // empty lane, nothing to write
          end
        end
        wAck: if (ackSync) begin
          wordReq <= 1'b0;
          state   <= wDrop;
        end
        wDrop: if (!ackSync) state <= wNext;
        wNext: begin
          if (!lastLane) begin
            lane  <= lane + LaneBits'(1);
            state <= wLane;
          end else if (lastBeat) begin
            BVALID <= 1'b1;
            state  <= wResp;
          end else begin
            beatCnt <= beatCnt + 1'b1;
            lane    <= LaneBits'(axiApbPkg::laneOf(axiApbPkg::addrWord'(nextAddr), BusBytes));
            WREADY  <= 1'b1;
            state   <= wData;
          end
        end
        wResp: if (BREADY) begin
          BVALID   <= 1'b0;
          portWant <= 1'b0;  // grant kept until B is taken
          state    <= wIdle;
        end
        default: state <= wIdle;
      endcase
    end
  end

  // captured fields and word-port payload
  always_ff @(posedge ACLK) begin
    if (state == wAddr) begin
      awId      <= AWID;
      beatAddr  <= AWADDR;
      burstLen  <= AWLEN;
      beatSize  <= AWSIZE;
      burstType <= axiApbPkg::burstKind'(AWBURST);
    end
    if (state == wData && WVALID) begin
      beatData <= WDATA;
      beatStrb <= WSTRB;
    end
    if (state == wLane) begin
      wordAddr <= laneAddr;
      wordData <= beatData[lane*axiApbPkg::wordWidth +: axiApbPkg::wordWidth];
      wordBe   <= laneBe;
    end
    if (state == wNext && lastLane) beatAddr <= nextAddr;
    if (state == wNext && lastLane && lastBeat) begin
      BID   <= awId;
      BRESP <= (missingLast || burstType == axiApbPkg::burstWrap) ?
               axiApbPkg::respSlvErr : axiApbPkg::respOkay;
    end
  end

endmodule

//--- rtl/axiApbPkg.sv
// shared widths, AXI burst and response codes, and address helpers used by every bridge module
package axiApbPkg;

  // ------------------------------
  // widths and field types
  // ------------------------------
  localparam int wordWidth = 32;             // one word-port transfer
  localparam int wordBytes = wordWidth / 8;  // byte enables per word

  typedef logic [7:0]  axiLen;    // beats minus one
  typedef logic [2:0]  axiSize;   // log2 of bytes per beat
  typedef logic [63:0] addrWord;  // widest address the helpers take

  typedef enum logic [1:0] {
    burstFixed = 2'b00,
    burstIncr  = 2'b01,
    burstWrap  = 2'b10
  } burstKind;

  typedef enum logic [1:0] {
    respOkay   = 2'b00,
    respSlvErr = 2'b10
  } respCode;

  // ------------------------------
  // address helpers
  // ------------------------------

  // word lane within the data bus that addr points at
  function automatic logic [1:0] laneOf(input addrWord addr, input int unsigned busBytes);
    addrWord offset;
    offset = addr & (addrWord'(busBytes) - addrWord'(1));
    return offset[3:2];
  endfunction

  function automatic addrWord nextBeatAddr(input addrWord addr, input axiSize size,
                                           input burstKind burst, input int unsigned busBytes);
    addrWord step;
    addrWord busMask;
    addrWord next;
    step    = addrWord'(1) << size;
    busMask = addrWord'(busBytes) - addrWord'(1);
    if (burst != burstIncr) begin
      next = addr;  // wrap is stepped like fixed
    end else if (step < addrWord'(busBytes)) begin
      next = addr + step;  // narrow beat
    end else begin
      next = (addr & ~busMask) + addrWord'(busBytes);
    end
    return next;
  endfunction

  // byte lanes a read beat covers, size-many ones moved to the bus offset
  function automatic logic [15:0] sizeMask(input addrWord addr, input axiSize size,
                                           input int unsigned busBytes);
    logic [31:0] ones;
    addrWord     offset;
    ones   = (32'd1 << (32'd1 << size)) - 32'd1;
    offset = addr & (addrWord'(busBytes) - addrWord'(1));
    return 16'(ones << offset[3:0]);
  endfunction

endpackage
